// ==== common/histogram_config.svh ====
`ifndef HISTOGRAM_CONFIG_SVH
`define HISTOGRAM_CONFIG_SVH

// raw sample width in codes
`define NP_WIDTH 10

// bins per histogram, same for coarse and fine
`define NB_BINS 16

// bin address width
`define NB_WIDTH 4

// bin counter width, counters stick at all ones
`define PEAK_MAX 4

// accepted samples per histogram pass
// out of window samples are counted as well
`define SAMPLES_PER_HIS 8

// sample to coarse bin, 64 codes per bin
`define CH_SHIFT 6

// window offset to fine bin, 4 codes per bin
`define FH_SHIFT 2

`endif

// ==== common/histCtrlPkg.sv ====
// control encodings shared by the histogram blocks
package histCtrlPkg;

    // builder sequence
    // one clear cycle ahead of each acquisition pass
    typedef enum logic [2:0] {
        CLEAR_CH,
        ACQ_CH,
        CLEAR_FH,
        ACQ_FH,
        REPORT
    } hisState_e;

    // which histogram is being built
    // selects the mapper mode and the peak register
    typedef enum logic {
        PHASE_CH,
        PHASE_FH
    } hisPhase_e;

endpackage

// ==== common/histDataPkg.sv ====
`include "histogram_config.svh"

// data types of the histogram path
package histDataPkg;

    // raw time sample, also used for window limits
    typedef logic [`NP_WIDTH-1:0] sample_t;

    // bin index inside one histogram
    typedef logic [`NB_WIDTH-1:0] binAddr_t;

    // saturating bin counter
    typedef logic [`PEAK_MAX-1:0] binCount_t;

endpackage

// ==== source/binMapper.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module binMapper
    import histCtrlPkg::*, histDataPkg::*;
(
    input  sample_t   roughData,
    input  hisPhase_e hisNum,
    input  sample_t   THminus,
    input  sample_t   THpositive,
    output binAddr_t  addr,
    output logic      outOfWindow
);

    sample_t coarseBin;
    sample_t fineOffset;
    sample_t fineBin;
    logic    inWindow;

    // coarse bin is just the top bits of the sample
    assign coarseBin = roughData >> `CH_SHIFT;

    // offset inside the fine window
    // wraps for samples below THminus, those get flagged anyway
    assign fineOffset = roughData - THminus;
    assign fineBin    = fineOffset >> `FH_SHIFT;

    // window limits are both inclusive
    assign inWindow = (roughData >= THminus) && (roughData <= THpositive);

    always_comb begin
        case (hisNum)
            PHASE_FH: begin
                // only low bits matter once inside the 64 code window
                addr        = binAddr_t'(fineBin);
                outOfWindow = !inWindow;
            end
            default: begin
                // coarse pass takes every sample
                addr        = binAddr_t'(coarseBin);
                outOfWindow = 1'b0;
            end
        endcase
    end

endmodule

// ==== histogram/hisBuilderFSM.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module hisBuilderFSM
    import histCtrlPkg::*, histDataPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      wrEn,
    input  binAddr_t  addr,
    input  logic      outOfWindow,
    output logic      acqReady,
    output hisPhase_e hisNum,
    output binCount_t binCounts,
    output binAddr_t  countAddr,
    output logic      countStrobe,
    output logic      acqCountFinish,
    output logic      resultValid
);

    localparam int CNT_W = $clog2(`SAMPLES_PER_HIS + 1);
    localparam logic [CNT_W-1:0] LAST_SAMPLE = CNT_W'(`SAMPLES_PER_HIS - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT  = CNT_W'(`SAMPLES_PER_HIS);

    hisState_e        state;
    hisState_e        nextState;
    logic [CNT_W-1:0] sampleCount;
    logic             finishDly;
    logic             accept;
    logic             binHit;
    logic             clearBins;
    binCount_t        hisBins [`NB_BINS];

    // ready only while a pass still needs samples
    // drops right after the last accepted one
    assign acqReady  = ((state == ACQ_CH) || (state == ACQ_FH)) && (sampleCount != FULL_COUNT);
    assign accept    = wrEn && acqReady;
    // out of window samples count but leave the bins alone
    assign binHit    = accept && !outOfWindow;
    assign clearBins = (state == CLEAR_CH) || (state == CLEAR_FH);

    // CLEAR_FH still reports the coarse phase,
    // the coarse peakDone lands in that cycle
    assign hisNum = ((state == ACQ_FH) || (state == REPORT)) ? PHASE_FH : PHASE_CH;

    assign resultValid = (state == REPORT);

    // last updated bin, valid with countStrobe
    assign binCounts = hisBins[countAddr];

    always_comb begin
        nextState = state;
        case (state)
            CLEAR_CH: nextState = ACQ_CH;
            ACQ_CH:   if (acqCountFinish) nextState = CLEAR_FH;
            CLEAR_FH: nextState = ACQ_FH;
            // one extra cycle so peakValue is registered before REPORT
            ACQ_FH:   if (finishDly) nextState = REPORT;
            REPORT:   nextState = CLEAR_CH;
            default:  nextState = CLEAR_CH;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state          <= CLEAR_CH;
            sampleCount    <= '0;
            countStrobe    <= 1'b0;
            acqCountFinish <= 1'b0;
            finishDly      <= 1'b0;
        end else begin
            state          <= nextState;
            countStrobe    <= binHit;
            acqCountFinish <= accept && (sampleCount == LAST_SAMPLE);
            finishDly      <= acqCountFinish;
            if (clearBins) begin
                sampleCount <= '0;
            end else if (accept) begin
                sampleCount <= sampleCount + 1'b1;
            end
        end
    end

    // bin storage, wiped in every clear cycle
    always_ff @(posedge clk) begin
        if (clearBins) begin
            for (int i = 0; i < `NB_BINS; i++) begin
                hisBins[i] <= '0;
            end
        end else if (binHit && (hisBins[addr] != '1)) begin
            // saturate at all ones
            hisBins[addr] <= hisBins[addr] + 1'b1;
        end
        if (binHit) begin
            countAddr <= addr;
        end
    end

endmodule

// ==== histogram/peakDetecter.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module peakDetecter
    import histCtrlPkg::*, histDataPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  binCount_t binCounts,
    input  binAddr_t  countAddr,
    input  logic      countStrobe,
    input  logic      acqCountFinish,
    input  hisPhase_e hisNum,
    output binAddr_t  peakCH,
    output binAddr_t  peakFH,
    output logic      peakDone
);

    binCount_t bestCount;
    binAddr_t  bestAddr;
    logic      newBest;
    binAddr_t  finalAddr;

    // strictly greater, so on a tie the earlier bin stays
    assign newBest = countStrobe && (binCounts > bestCount);

    // the last update of a pass arrives with acqCountFinish,
    // fold it in before latching
    assign finalAddr = newBest ? countAddr : bestAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bestCount <= '0;
            bestAddr  <= '0;
            peakCH    <= '0;
            peakFH    <= '0;
            peakDone  <= 1'b0;
        end else begin
            peakDone <= acqCountFinish;
            if (acqCountFinish) begin
                // end of pass, restart the search for the next one
                bestCount <= '0;
                bestAddr  <= '0;
                // peakCH moves at every coarse end, peakFH only at the fine end
                if (hisNum == PHASE_CH) begin
                    peakCH <= finalAddr;
                end else begin
                    peakFH <= finalAddr;
                end
            end else if (newBest) begin
                bestCount <= binCounts;
                bestAddr  <= countAddr;
            end
        end
    end

endmodule

// ==== source/windowCalc.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module windowCalc
    import histCtrlPkg::*, histDataPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  binAddr_t  peakCH,
    input  logic      peakDone,
    input  hisPhase_e hisNum,
    input  binAddr_t  peakFH,
    output sample_t   THminus,
    output sample_t   THpositive,
    output sample_t   delta,
    output sample_t   peakValue
);

    // window covers one full coarse bin
    localparam sample_t WIN_SPAN  = sample_t'((1 << `CH_SHIFT) - 1);
    // codes per fine bin
    localparam sample_t FINE_STEP = sample_t'(1 << `FH_SHIFT);

    sample_t chBase;

    // lowest code of the coarse peak bin
    assign chBase = sample_t'(peakCH) << `CH_SHIFT;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            THminus    <= '0;
            THpositive <= '0;
            delta      <= '0;
            peakValue  <= '0;
        end else if (peakDone) begin
            if (hisNum == PHASE_CH) begin
                THminus    <= chBase;
                THpositive <= chBase + WIN_SPAN;
                delta      <= FINE_STEP;
            end else begin
                // lower edge of the fine peak bin, ready for REPORT
                peakValue <= THminus + sample_t'(peakFH) * delta;
            end
        end
    end

endmodule

// ==== source/peakFinderTop.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module peakFinderTop
    import histCtrlPkg::*, histDataPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     wrEn,
    input  sample_t  roughData,
    output logic     acqReady,
    output logic     resultValid,
    output binAddr_t peakCH,
    output binAddr_t peakFH,
    output sample_t  peakValue
);

    hisPhase_e hisNum;
    binAddr_t  addr;
    logic      outOfWindow;
    sample_t   THminus;
    sample_t   THpositive;
    binCount_t binCounts;
    binAddr_t  countAddr;
    logic      countStrobe;
    logic      acqCountFinish;
    logic      peakDone;

    // sample to bin, coarse or fine by phase
    binMapper binMapperU0 (
        .roughData   (roughData),
        .hisNum      (hisNum),
        .THminus     (THminus),
        .THpositive  (THpositive),
        .addr        (addr),
        .outOfWindow (outOfWindow)
    );

    // counters and pass sequencing
    hisBuilderFSM hisBuilderFSMU0 (
        .clk            (clk),
        .arstN          (arstN),
        .wrEn           (wrEn),
        .addr           (addr),
        .outOfWindow    (outOfWindow),
        .acqReady       (acqReady),
        .hisNum         (hisNum),
        .binCounts      (binCounts),
        .countAddr      (countAddr),
        .countStrobe    (countStrobe),
        .acqCountFinish (acqCountFinish),
        .resultValid    (resultValid)
    );

    peakDetecter peakDetecterU0 (
        .clk            (clk),
        .arstN          (arstN),
        .binCounts      (binCounts),
        .countAddr      (countAddr),
        .countStrobe    (countStrobe),
        .acqCountFinish (acqCountFinish),
        .hisNum         (hisNum),
        .peakCH         (peakCH),
        .peakFH         (peakFH),
        .peakDone       (peakDone)
    );

    // fine bin width is only needed inside windowCalc
    windowCalc windowCalcU0 (
        .clk        (clk),
        .arstN      (arstN),
        .peakCH     (peakCH),
        .peakDone   (peakDone),
        .hisNum     (hisNum),
        .peakFH     (peakFH),
        .THminus    (THminus),
        .THpositive (THpositive),
        .delta      (),
        .peakValue  (peakValue)
    );

endmodule

// ==== bench/peakFinderTb.sv ====
`timescale 1ns/1ps
`include "histogram_config.svh"

module peakFinderTb
    import histDataPkg::*;
();

    // four hand rows, then three random ones
    localparam int ROWS        = 7;
    localparam int ROW_LEN     = 2 * `SAMPLES_PER_HIS;
    localparam int ROW_W       = 27 + ROW_LEN * `NP_WIDTH;
    localparam int CYCLE_LIMIT = 40 * ROWS + 100;

    logic     clk;
    logic     arstN;
    logic     wrEn;
    sample_t  roughData;
    logic     acqReady;
    logic     resultValid;
    binAddr_t peakCH;
    binAddr_t peakFH;
    sample_t  peakValue;

    sample_t  rowData [ROWS][ROW_LEN];
    binAddr_t expCH [ROWS];
    binAddr_t expFH [ROWS];
    sample_t  expValue [ROWS];
    int       seed;
    int       curRow;
    int       idx;
    int       cycles;

    peakFinderTop u_dut (.*);

    always #5 clk = ~clk;

    // random flag, fine window mask, expected peakCH peakFH peakValue
    // followed by 8 coarse and 8 fine samples
    function automatic logic [ROW_W-1:0] tableRow(input int r);
        case (r)
            // cluster near 0x158
            0: tableRow = {1'b0, 8'h00, 4'h5, 4'h6, 10'h158,
                10'h150, 10'h155, 10'h020, 10'h152, 10'h3f0, 10'h15a, 10'h156, 10'h151,
                10'h15a, 10'h158, 10'h159, 10'h141, 10'h15b, 10'h170, 10'h158, 10'h15a};
            // bins 12 and 3 both reach 3 but bin 12 gets there first
            1: tableRow = {1'b0, 8'h00, 4'hc, 4'h1, 10'h304,
                10'h0c5, 10'h310, 10'h312, 10'h0c8, 10'h31f, 10'h0d0, 10'h200, 10'h201,
                10'h304, 10'h33c, 10'h33d, 10'h306, 10'h320, 10'h307, 10'h33f, 10'h321};
            // six fine samples miss the window and five of them would alias to fine bin 3
            2: tableRow = {1'b0, 8'h00, 4'h1, 4'ha, 10'h068,
                10'h041, 10'h07e, 10'h050, 10'h060, 10'h044, 10'h045, 10'h070, 10'h071,
                10'h068, 10'h08c, 10'h0cd, 10'h06a, 10'h10e, 10'h3cc, 10'h00c, 10'h03f};
            // every sample of each pass piles into one bin
            3: tableRow = {1'b0, 8'h00, 4'hf, 4'hd, 10'h3f4,
                10'h3c3, 10'h3ff, 10'h3c0, 10'h3e2, 10'h3d1, 10'h3c4, 10'h3f9, 10'h3ee,
                10'h3f4, 10'h3f5, 10'h3f6, 10'h3f7, 10'h3f4, 10'h3f7, 10'h3f5, 10'h3f6};
            // mask bits pick fine samples drawn inside the window
            4: tableRow = {1'b1, 8'hff, 4'h0, 4'h0, 10'h000, 160'h0};
            5: tableRow = {1'b1, 8'h5a, 4'h0, 4'h0, 10'h000, 160'h0};
            default: tableRow = {1'b1, 8'h00, 4'h0, 4'h0, 10'h000, 160'h0};
        endcase
    endfunction

    // running maximum per pass with counters stuck at 15
    task automatic predictRow(input int r, output binAddr_t ch, output binAddr_t fh,
                              output sample_t val);
        int cnt [`NB_BINS];
        int best;
        int bin;
        int s;
        int lo;
        lo = 0;
        ch = '0;
        fh = '0;
        for (int p = 0; p < 2; p++) begin
            for (int b = 0; b < `NB_BINS; b++) begin
                cnt[b] = 0;
            end
            best = 0;
            for (int i = 0; i < `SAMPLES_PER_HIS; i++) begin
                s = int'(rowData[r][p * `SAMPLES_PER_HIS + i]);
                // coarse bins are 64 codes wide and fine bins 4 codes wide
                bin = (p == 0) ? s / 64 : (s - lo) / 4;
                if ((p == 0) || (s >= lo && s <= lo + 63)) begin
                    if (cnt[bin] < 15) begin
                        cnt[bin]++;
                    end
                    // only a strictly larger count moves the peak
                    if (cnt[bin] > best) begin
                        best = cnt[bin];
                        if (p == 0) begin
                            ch = binAddr_t'(bin);
                        end else begin
                            fh = binAddr_t'(bin);
                        end
                    end
                end
            end
            lo = int'(ch) * 64;
        end
        val = sample_t'(lo + int'(fh) * 4);
    endtask

    task automatic loadTable();
        logic [ROW_W-1:0] row;
        binAddr_t         ch;
        binAddr_t         fh;
        sample_t          val;
        for (int r = 0; r < ROWS; r++) begin
            row         = tableRow(r);
            expCH[r]    = row[ROW_W-10 -: 4];
            expFH[r]    = row[ROW_W-14 -: 4];
            expValue[r] = row[ROW_W-18 -: 10];
            for (int i = 0; i < ROW_LEN; i++) begin
                rowData[r][i] = row[ROW_LEN*10-1 - i*10 -: 10];
            end
            if (row[ROW_W-1]) begin
                // coarse half first so its peak places the window for the fine half
                for (int i = 0; i < `SAMPLES_PER_HIS; i++) begin
                    rowData[r][i] = sample_t'($random(seed));
                end
                predictRow(r, ch, fh, val);
                for (int i = 0; i < `SAMPLES_PER_HIS; i++) begin
                    if (row[ROW_W-9+i]) begin
                        rowData[r][`SAMPLES_PER_HIS+i] =
                            sample_t'(int'(ch) * 64 + ($random(seed) & 63));
                    end else begin
                        rowData[r][`SAMPLES_PER_HIS+i] = sample_t'($random(seed));
                    end
                end
                predictRow(r, expCH[r], expFH[r], expValue[r]);
            end
        end
    endtask

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp)
        else stopWithError($sformatf("CHECK FAILED %s row %0d got 0x%0h expected 0x%0h",
                                     name, curRow, got, exp));
    endtask

    // run length bound grows with the row count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            stopWithError($sformatf("timeout after %0d cycles, no result for row %0d",
                                    cycles, curRow));
        end
    end

    initial begin
        clk       = 1'b0;
        arstN     = 1'b0;
        wrEn      = 1'b0;
        roughData = '0;
        seed      = 32'hb85;
        cycles    = 0;
        curRow    = 0;
        idx       = 0;
        loadTable();
        repeat (10) @(posedge clk);
        #1;
        assert (acqReady == 1'b0)
        else stopWithError($sformatf("CHECK FAILED acqReady in reset got 0x%0h expected 0x0",
                                     acqReady));
        assert (resultValid == 1'b0)
        else stopWithError($sformatf("CHECK FAILED resultValid in reset got 0x%0h expected 0x0",
                                     resultValid));
        arstN = 1'b1;
        // rows go back to back with no idle gap
        while (curRow < ROWS) begin
            @(posedge clk);
            #1;
            if (resultValid) begin
                assert (idx == ROW_LEN)
                else stopWithError($sformatf("resultValid came after %0d samples of row %0d",
                                             idx, curRow));
                checkValue("peakCH", peakCH, expCH[curRow]);
                checkValue("peakFH", peakFH, expFH[curRow]);
                checkValue("peakValue", peakValue, expValue[curRow]);
                curRow++;
                idx = 0;
            end
            wrEn = 1'b1;
            if (curRow < ROWS && acqReady && idx < ROW_LEN) begin
                roughData = rowData[curRow][idx];
                idx++;
            end else begin
                // junk offered in clear and report cycles has to be dropped
                roughData = sample_t'($random(seed));
            end
        end
        wrEn = 1'b0;
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/histCtrlPkg.sv
common/histDataPkg.sv
source/binMapper.sv
histogram/hisBuilderFSM.sv
histogram/peakDetecter.sv
source/windowCalc.sv
source/peakFinderTop.sv
bench/peakFinderTb.sv

// ==== Bender.yml ====
package:
  name: peak_finder

sources:
  - include_dirs:
      - common
    files:
      - common/histCtrlPkg.sv
      - common/histDataPkg.sv
      - source/binMapper.sv
      - histogram/hisBuilderFSM.sv
      - histogram/peakDetecter.sv
      - source/windowCalc.sv
      - source/peakFinderTop.sv
      - target: test
        include_dirs:
          - common
        files:
          - bench/peakFinderTb.sv
